// File: Makefile
VERILATOR ?= verilator
TOP       := execUnit_tb
FILELIST  := execUnit.f
VFLAGS    := --binary --timing --assert -j 0
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log

SOURCES   := $(shell grep -v '^+' $(FILELIST)) rtl/exec_macros.svh

.PHONY: all run clean

all: run

# Rebuild only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: execUnit.f
+incdir+rtl
rtl/execPkg.sv
rtl/aluUnit.sv
rtl/branchUnit.sv
rtl/resultMerge.sv
rtl/execUnit.sv
test/execUnit_assert.sv
test/execUnit_tb.sv

// File: rtl/aluUnit.sv
`timescale 1ns/1ps

`include "exec_macros.svh"

module aluUnit (
  input  execPkg::instWord_u   inst,
  input  logic [`DBITS-1:0]    regVal1,
  input  logic [`DBITS-1:0]    regVal2,
  output logic [`DBITS-1:0]    aluResult
);

  logic [`DBITS-1:0] sxtImm;
  logic [`DBITS-1:0] aluOp;

  // Immediate is always sign extended
  assign sxtImm = {{(`DBITS-`IMMBITS){inst.imm.imm[`IMMBITS-1]}}, inst.imm.imm};

  // ==================================================
  // Register-register operations
  // ==================================================
  always_comb begin
    case (inst.alur.op2)
      // Compares are signed and give 0 or 1
      `OP2_EQ:   aluOp = {{(`DBITS-1){1'b0}}, regVal1 == regVal2};
      `OP2_LT:   aluOp = {{(`DBITS-1){1'b0}}, $signed(regVal1) < $signed(regVal2)};
      `OP2_LE:   aluOp = {{(`DBITS-1){1'b0}}, $signed(regVal1) <= $signed(regVal2)};
      `OP2_NE:   aluOp = {{(`DBITS-1){1'b0}}, regVal1 != regVal2};
      `OP2_ADD:  aluOp = regVal1 + regVal2;
      `OP2_AND:  aluOp = regVal1 & regVal2;
      `OP2_OR:   aluOp = regVal1 | regVal2;
      `OP2_XOR:  aluOp = regVal1 ^ regVal2;
      `OP2_SUB:  aluOp = regVal1 - regVal2;
      `OP2_NAND: aluOp = ~(regVal1 & regVal2);
      `OP2_NOR:  aluOp = ~(regVal1 | regVal2);
      `OP2_NXOR: aluOp = regVal1 ~^ regVal2;
      // Logical shift right, zero fill
      `OP2_RSHF: aluOp = regVal1 >> regVal2;
      `OP2_LSHF: aluOp = regVal1 << regVal2;
      default:   aluOp = '0;
    endcase
  end

  // ==================================================
  // Result by primary opcode
  // ==================================================
  always_comb begin
    case (inst.imm.op1)
      `OP1_ALUR: begin
        aluResult = aluOp;
      end
      // Address generation for memory ops uses the same adder as ADDI
      `OP1_ADDI, `OP1_LW, `OP1_SW: begin
        aluResult = regVal1 + sxtImm;
      end
      `OP1_ANDI: begin
        aluResult = regVal1 & sxtImm;
      end
      `OP1_ORI: begin
        aluResult = regVal1 | sxtImm;
      end
      `OP1_XORI: begin
        aluResult = regVal1 ^ sxtImm;
      end
      default: begin
        // JAL takes its link value in resultMerge
        aluResult = '0;
      end
    endcase
  end

endmodule

// File: rtl/branchUnit.sv
`timescale 1ns/1ps

`include "exec_macros.svh"

module branchUnit (
  input  execPkg::instWord_u   inst,
  input  logic [`DBITS-1:0]    pcPlus,
  input  logic [`DBITS-1:0]    regVal1,
  input  logic [`DBITS-1:0]    regVal2,
  output logic                 taken,
  output logic                 isLink,
  output logic [`DBITS-1:0]    branchTarget
);

  logic [`DBITS-1:0] sxtImm;
  logic [`DBITS-1:0] wordOffset;
  logic              condMet;

  assign sxtImm = {{(`DBITS-`IMMBITS){inst.imm.imm[`IMMBITS-1]}}, inst.imm.imm};

  // Offset counts instruction words
  assign wordOffset = {sxtImm[`DBITS-3:0], 2'b00};

  // ==================================================
  // Branch condition
  // ==================================================
  always_comb begin
    case (inst.imm.op1)
      `OP1_BEQ: condMet = regVal1 == regVal2;
      `OP1_BLT: condMet = $signed(regVal1) < $signed(regVal2);
      `OP1_BLE: condMet = $signed(regVal1) <= $signed(regVal2);
      `OP1_BNE: condMet = regVal1 != regVal2;
      default:  condMet = 1'b0;
    endcase
  end

  // JAL always redirects and links
  assign isLink = inst.imm.op1 == `OP1_JAL;
  assign taken  = condMet | isLink;

  // Branches are PC relative, JAL is register relative
  assign branchTarget = isLink ? (regVal1 + wordOffset) : (pcPlus + wordOffset);

endmodule

// File: rtl/execPkg.sv
`include "exec_macros.svh"

package execPkg;

  // ==================================================
  // Instruction word
  // ==================================================

  // Register-register format and immediate format overlay the same word
  typedef union packed {
    // ALUR view
    struct packed {
      logic [`OP1BITS-1:0]   op1;
      logic [`OP2BITS-1:0]   op2;
      logic [5:0]            spare;
      logic [`REGNOBITS-1:0] rd;
      logic [`REGNOBITS-1:0] rs;
      logic [`REGNOBITS-1:0] rt;
    } alur;

    // Immediate, memory, branch and jump view
    struct packed {
      logic [`OP1BITS-1:0]   op1;
      logic [1:0]            spare;
      logic [`IMMBITS-1:0]   imm;
      logic [`REGNOBITS-1:0] rs;
      logic [`REGNOBITS-1:0] rt;
    } imm;
  } instWord_u;

endpackage

// File: rtl/execUnit.sv
`timescale 1ns/1ps

`include "exec_macros.svh"

module execUnit (
  input  logic                   clk,
  input  logic                   RESET,
  input  logic                   inValid,
  input  logic [`INSTBITS-1:0]   inst,
  input  logic [`DBITS-1:0]      pcPlus,
  input  logic [`DBITS-1:0]      regVal1,
  input  logic [`DBITS-1:0]      regVal2,
  output logic                   outValid,
  output logic [`DBITS-1:0]      result,
  output logic                   wrReg,
  output logic [`REGNOBITS-1:0]  wregNo,
  output logic                   redirect,
  output logic [`DBITS-1:0]      target
);

  logic [`DBITS-1:0] aluResult;
  logic              taken;
  logic              isLink;
  logic [`DBITS-1:0] branchTarget;

  // ==================================================
  // Combinational datapath
  // ==================================================
  aluUnit alu (
    .inst      (inst),
    .regVal1   (regVal1),
    .regVal2   (regVal2),
    .aluResult (aluResult)
  );

  branchUnit branch (
    .inst         (inst),
    .pcPlus       (pcPlus),
    .regVal1      (regVal1),
    .regVal2      (regVal2),
    .taken        (taken),
    .isLink       (isLink),
    .branchTarget (branchTarget)
  );

  // Single register stage
  resultMerge merge (
    .clk          (clk),
    .RESET        (RESET),
    .inValid      (inValid),
    .inst         (inst),
    .pcPlus       (pcPlus),
    .aluResult    (aluResult),
    .taken        (taken),
    .isLink       (isLink),
    .branchTarget (branchTarget),
    .outValid     (outValid),
    .result       (result),
    .wrReg        (wrReg),
    .wregNo       (wregNo),
    .redirect     (redirect),
    .target       (target)
  );

endmodule

// File: rtl/exec_macros.svh
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// ==================================================
// Datapath widths
// ==================================================
`define DBITS      32
`define INSTBITS   32
`define REGNOBITS  4
`define IMMBITS    16
`define OP1BITS    6
`define OP2BITS    8

// ==================================================
// Primary opcodes
// ==================================================
`define OP1_ALUR   6'b000000
// Conditional branches share the 001 prefix with JAL
`define OP1_BEQ    6'b001000
`define OP1_BLT    6'b001001
`define OP1_BLE    6'b001010
`define OP1_BNE    6'b001011
`define OP1_JAL    6'b001100
`define OP1_LW     6'b010010
`define OP1_SW     6'b011010
`define OP1_ADDI   6'b100000
`define OP1_ANDI   6'b100100
`define OP1_ORI    6'b100101
`define OP1_XORI   6'b100110

// ==================================================
// Secondary opcodes for ALUR
// ==================================================
`define OP2_EQ     8'b00001000
`define OP2_LT     8'b00001001
`define OP2_LE     8'b00001010
`define OP2_NE     8'b00001011
`define OP2_ADD    8'b00100000
`define OP2_AND    8'b00100100
`define OP2_OR     8'b00100101
`define OP2_XOR    8'b00100110
`define OP2_SUB    8'b00101000
`define OP2_NAND   8'b00101100
`define OP2_NOR    8'b00101101
`define OP2_NXOR   8'b00101110
`define OP2_RSHF   8'b00110000
`define OP2_LSHF   8'b00110001

`endif

// File: rtl/resultMerge.sv
`timescale 1ns/1ps

`include "exec_macros.svh"

module resultMerge (
  input  logic                   clk,
  input  logic                   RESET,
  input  logic                   inValid,
  input  execPkg::instWord_u     inst,
  input  logic [`DBITS-1:0]      pcPlus,
  input  logic [`DBITS-1:0]      aluResult,
  input  logic                   taken,
  input  logic                   isLink,
  input  logic [`DBITS-1:0]      branchTarget,
  output logic                   outValid,
  output logic [`DBITS-1:0]      result,
  output logic                   wrReg,
  output logic [`REGNOBITS-1:0]  wregNo,
  output logic                   redirect,
  output logic [`DBITS-1:0]      target
);

  logic                  writes;
  logic                  isAlur;
  logic [`REGNOBITS-1:0] destReg;
  logic [`DBITS-1:0]     wbValue;

  // ==================================================
  // Writeback decode
  // ==================================================

  // Conditional branches and stores leave the register file alone
  always_comb begin
    case (inst.imm.op1)
      `OP1_BEQ, `OP1_BLT, `OP1_BLE, `OP1_BNE, `OP1_SW: writes = 1'b0;
      default: writes = 1'b1;
    endcase
  end

  // Rd for ALUR, rt for everything else
  assign isAlur  = inst.alur.op1 == `OP1_ALUR;
  assign destReg = isAlur ? inst.alur.rd : inst.imm.rt;

  // JAL writes back the return address
  assign wbValue = isLink ? pcPlus : aluResult;

  // ==================================================
  // Output register
  // ==================================================
  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      outValid <= 1'b0;
      wrReg    <= 1'b0;
      redirect <= 1'b0;
      result   <= '0;
      wregNo   <= '0;
      target   <= '0;
    end else begin
      // Strobes only assert alongside a valid item
      outValid <= inValid;
      wrReg    <= inValid & writes;
      redirect <= inValid & taken;
      if (inValid) begin
        result <= wbValue;
        wregNo <= destReg;
        target <= branchTarget;
      end
    end
  end

endmodule

// File: test/execUnit_assert.sv
`timescale 1ns/1ps

`include "exec_macros.svh"

module execUnit_assert (
  input logic                  clk,
  input logic                  RESET,
  input logic                  inValid,
  input logic                  outValid,
  input logic                  wrReg,
  input logic                  redirect,
  input logic [`DBITS-1:0]     result,
  input logic [`DBITS-1:0]     target,
  input logic [`REGNOBITS-1:0] wregNo
);

  // ==================================================
  // Output timing
  // ==================================================

  // One register stage between strobes
  validFollowsInput: assert property (@(posedge clk) disable iff (RESET)
    outValid == $past(inValid))
    else $error("outValid does not follow inValid of the previous cycle");

  redirectNeedsValid: assert property (@(posedge clk) disable iff (RESET)
    redirect |-> outValid)
    else $error("redirect is high without outValid");

  writeNeedsValid: assert property (@(posedge clk) disable iff (RESET)
    wrReg |-> outValid)
    else $error("wrReg is high without outValid");

  // All outputs cleared while reset is held
  quietInReset: assert property (@(posedge clk)
    RESET |-> (!outValid && !wrReg && !redirect &&
               result == '0 && target == '0 && wregNo == '0))
    else $error("an output is not cleared during reset");

endmodule

bind execUnit execUnit_assert timingCheck (
  .clk      (clk),
  .RESET    (RESET),
  .inValid  (inValid),
  .outValid (outValid),
  .wrReg    (wrReg),
  .redirect (redirect),
  .result   (result),
  .target   (target),
  .wregNo   (wregNo)
);

// File: test/execUnit_tb.sv
`timescale 1ns/1ps

`include "exec_macros.svh"

module execUnit_tb;

  localparam int MAXROWS = 64;

  typedef struct {
    logic                  valid;
    logic [`INSTBITS-1:0]  inst;
    logic [`DBITS-1:0]     val1;
    logic [`DBITS-1:0]     val2;
    logic [`DBITS-1:0]     pc;
    logic [`DBITS-1:0]     expResult;
    logic                  expWrReg;
    logic [`REGNOBITS-1:0] expWregNo;
    logic                  expRedirect;
    logic [`DBITS-1:0]     expTarget;
  } stimRow_t;

  logic                  clk;
  logic                  RESET;
  logic                  inValid;
  logic [`INSTBITS-1:0]  inst;
  logic [`DBITS-1:0]     pcPlus;
  logic [`DBITS-1:0]     regVal1;
  logic [`DBITS-1:0]     regVal2;
  logic                  outValid;
  logic [`DBITS-1:0]     result;
  logic                  wrReg;
  logic [`REGNOBITS-1:0] wregNo;
  logic                  redirect;
  logic [`DBITS-1:0]     target;

  stimRow_t    rows [MAXROWS];
  int          rowCount = 0;
  int          cycleCount = 0;

  execUnit dut (
    .clk      (clk),
    .RESET    (RESET),
    .inValid  (inValid),
    .inst     (inst),
    .pcPlus   (pcPlus),
    .regVal1  (regVal1),
    .regVal2  (regVal2),
    .outValid (outValid),
    .result   (result),
    .wrReg    (wrReg),
    .wregNo   (wregNo),
    .redirect (redirect),
    .target   (target)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Run limit follows the table length
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount > rowCount + 20) begin
      $display("Timeout: the run took more cycles than the stimulus table needs");
      $display("TEST FAIL");
      $fatal(1, "Simulation timed out");
    end
  end

  // ==================================================
  // Reference model
  // ==================================================
  function automatic logic [`DBITS-1:0] signExt(input logic [`IMMBITS-1:0] imm);
    if (imm[`IMMBITS-1])
      return {16'hFFFF, imm};
    else
      return {16'h0000, imm};
  endfunction

  function automatic logic [`DBITS-1:0] asWord(input logic b);
    return b ? 32'd1 : 32'd0;
  endfunction

  function automatic logic [`DBITS-1:0] alurModel(input logic [`OP2BITS-1:0] op2,
                                                  input logic [`DBITS-1:0] a,
                                                  input logic [`DBITS-1:0] b);
    case (op2)
      `OP2_EQ:   return asWord(a == b);
      `OP2_LT:   return asWord($signed(a) < $signed(b));
      `OP2_LE:   return asWord($signed(a) <= $signed(b));
      `OP2_NE:   return asWord(a != b);
      `OP2_ADD:  return a + b;
      `OP2_AND:  return a & b;
      `OP2_OR:   return a | b;
      `OP2_XOR:  return a ^ b;
      `OP2_SUB:  return a - b;
      `OP2_NAND: return ~(a & b);
      `OP2_NOR:  return ~(a | b);
      `OP2_NXOR: return ~(a ^ b);
      `OP2_RSHF: return a >> b;
      `OP2_LSHF: return a << b;
      default:   return '0;
    endcase
  endfunction

  function automatic logic [`DBITS-1:0] modelResult(input execPkg::instWord_u w,
                                                    input logic [`DBITS-1:0] a,
                                                    input logic [`DBITS-1:0] b,
                                                    input logic [`DBITS-1:0] pc);
    logic [`DBITS-1:0] imm32;
    imm32 = signExt(w.imm.imm);
    case (w.imm.op1)
      `OP1_JAL:                    return pc;
      `OP1_ALUR:                   return alurModel(w.alur.op2, a, b);
      `OP1_ADDI, `OP1_LW, `OP1_SW: return a + imm32;
      `OP1_ANDI:                   return a & imm32;
      `OP1_ORI:                    return a | imm32;
      `OP1_XORI:                   return a ^ imm32;
      default:                     return '0;
    endcase
  endfunction

  function automatic logic modelWrReg(input logic [`OP1BITS-1:0] op1);
    return !(op1 == `OP1_BEQ || op1 == `OP1_BLT || op1 == `OP1_BLE ||
             op1 == `OP1_BNE || op1 == `OP1_SW);
  endfunction

  function automatic logic [`REGNOBITS-1:0] modelWregNo(input execPkg::instWord_u w);
    case (w.imm.op1)
      `OP1_ALUR: return w.alur.rd;
      default:   return w.imm.rt;
    endcase
  endfunction

  function automatic logic modelRedirect(input execPkg::instWord_u w,
                                         input logic [`DBITS-1:0] a,
                                         input logic [`DBITS-1:0] b);
    case (w.imm.op1)
      `OP1_BEQ: return a == b;
      `OP1_BLT: return $signed(a) < $signed(b);
      `OP1_BLE: return $signed(a) <= $signed(b);
      `OP1_BNE: return a != b;
      `OP1_JAL: return 1'b1;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic logic [`DBITS-1:0] modelTarget(input execPkg::instWord_u w,
                                                    input logic [`DBITS-1:0] a,
                                                    input logic [`DBITS-1:0] pc);
    logic [`DBITS-1:0] offset;
    offset = signExt(w.imm.imm) * 32'd4;
    return ((w.imm.op1 == `OP1_JAL) ? a : pc) + offset;
  endfunction

  // ==================================================
  // Stimulus table
  // ==================================================
  function automatic execPkg::instWord_u alurInst(input logic [`OP2BITS-1:0] op2,
                                                  input logic [`REGNOBITS-1:0] rd);
    execPkg::instWord_u w;
    w = '0;
    w.alur.op1 = `OP1_ALUR;
    w.alur.op2 = op2;
    w.alur.rd  = rd;
    w.alur.rs  = 4'd1;
    w.alur.rt  = 4'd2;
    return w;
  endfunction

  function automatic execPkg::instWord_u immInst(input logic [`OP1BITS-1:0] op1,
                                                 input logic [`IMMBITS-1:0] imm,
                                                 input logic [`REGNOBITS-1:0] rt);
    execPkg::instWord_u w;
    w = '0;
    w.imm.op1 = op1;
    w.imm.imm = imm;
    w.imm.rs  = 4'd3;
    w.imm.rt  = rt;
    return w;
  endfunction

  task automatic addRow(input logic valid, input execPkg::instWord_u w,
                        input logic [`DBITS-1:0] a, input logic [`DBITS-1:0] b,
                        input logic [`DBITS-1:0] pc);
    stimRow_t r;
    r.valid       = valid;
    r.inst        = w;
    r.val1        = a;
    r.val2        = b;
    r.pc          = pc;
    r.expResult   = modelResult(w, a, b, pc);
    r.expWrReg    = valid & modelWrReg(w.imm.op1);
    r.expWregNo   = modelWregNo(w);
    r.expRedirect = valid & modelRedirect(w, a, b);
    r.expTarget   = modelTarget(w, a, pc);
    rows[rowCount] = r;
    rowCount++;
  endtask

  task automatic buildTable();
    logic [`DBITS-1:0] randA;
    logic [`DBITS-1:0] randB;
    // ALUR, signed compares on a negative operand
    addRow(1'b1, alurInst(`OP2_EQ, 4'd4), 32'hFFFF_FFFB, 32'hFFFF_FFFB, 32'h100);
    addRow(1'b1, alurInst(`OP2_EQ, 4'd5), 32'hFFFF_FFFB, 32'h0000_0003, 32'h104);
    addRow(1'b1, alurInst(`OP2_LT, 4'd6), 32'hFFFF_FFFB, 32'h0000_0003, 32'h108);
    addRow(1'b1, alurInst(`OP2_LT, 4'd7), 32'h0000_0003, 32'hFFFF_FFFB, 32'h10C);
    addRow(1'b1, alurInst(`OP2_LE, 4'd8), 32'h0000_0003, 32'h0000_0003, 32'h110);
    addRow(1'b1, alurInst(`OP2_LE, 4'd9), 32'h0000_0003, 32'hFFFF_FFFB, 32'h114);
    addRow(1'b1, alurInst(`OP2_NE, 4'd10), 32'hFFFF_FFFB, 32'h0000_0003, 32'h118);
    addRow(1'b1, alurInst(`OP2_ADD, 4'd11), 32'h7FFF_FFFF, 32'h0000_0001, 32'h11C);
    addRow(1'b1, alurInst(`OP2_AND, 4'd12), 32'hF0F0_1234, 32'h0FF0_FFFF, 32'h120);
    addRow(1'b1, alurInst(`OP2_OR, 4'd13), 32'hF0F0_1234, 32'h0FF0_00FF, 32'h124);
    addRow(1'b1, alurInst(`OP2_XOR, 4'd14), 32'hAAAA_5555, 32'hFFFF_0000, 32'h128);
    addRow(1'b1, alurInst(`OP2_SUB, 4'd15), 32'h0000_0003, 32'h0000_0005, 32'h12C);
    addRow(1'b1, alurInst(`OP2_NAND, 4'd1), 32'hFF00_FF00, 32'h0F0F_0F0F, 32'h130);
    addRow(1'b1, alurInst(`OP2_NOR, 4'd2), 32'hFF00_0000, 32'h0000_00F0, 32'h134);
    addRow(1'b1, alurInst(`OP2_NXOR, 4'd3), 32'h1234_5678, 32'h8765_4321, 32'h138);
    addRow(1'b1, alurInst(`OP2_RSHF, 4'd4), 32'h8000_0010, 32'h0000_0004, 32'h13C);
    addRow(1'b1, alurInst(`OP2_LSHF, 4'd5), 32'h0000_00F1, 32'h0000_0008, 32'h140);
    // Immediate forms with negative immediates
    addRow(1'b1, immInst(`OP1_ADDI, 16'hFFFF, 4'd3), 32'd100, 32'h0, 32'h200);
    addRow(1'b1, immInst(`OP1_ANDI, 16'hFF00, 4'd4), 32'h1234_5678, 32'h0, 32'h204);
    addRow(1'b1, immInst(`OP1_ORI, 16'h8001, 4'd5), 32'h0000_0000, 32'h0, 32'h208);
    addRow(1'b1, immInst(`OP1_XORI, 16'hF0F0, 4'd6), 32'h0000_FFFF, 32'h0, 32'h20C);
    addRow(1'b1, immInst(`OP1_LW, 16'hFFFC, 4'd7), 32'h0000_1000, 32'h0, 32'h210);
    addRow(1'b1, immInst(`OP1_SW, 16'hFFFC, 4'd8), 32'h0000_1000, 32'h5A5A, 32'h214);
    // Branches, taken then not taken
    addRow(1'b1, immInst(`OP1_BEQ, 16'hFFF0, 4'd1), 32'hFFFF_FFFB, 32'hFFFF_FFFB, 32'h400);
    addRow(1'b1, immInst(`OP1_BEQ, 16'hFFF0, 4'd1), 32'hFFFF_FFFB, 32'h0000_0003, 32'h404);
    addRow(1'b1, immInst(`OP1_BLT, 16'h0020, 4'd2), 32'hFFFF_FFFB, 32'h0000_0003, 32'h408);
    addRow(1'b1, immInst(`OP1_BLT, 16'h0020, 4'd2), 32'h0000_0003, 32'hFFFF_FFFB, 32'h40C);
    addRow(1'b1, immInst(`OP1_BLE, 16'h0008, 4'd3), 32'h0000_0003, 32'h0000_0003, 32'h410);
    addRow(1'b1, immInst(`OP1_BLE, 16'h0008, 4'd3), 32'h0000_0004, 32'h0000_0003, 32'h414);
    addRow(1'b1, immInst(`OP1_BNE, 16'h8000, 4'd4), 32'h0000_0001, 32'h0000_0002, 32'h418);
    addRow(1'b1, immInst(`OP1_BNE, 16'h8000, 4'd4), 32'h0000_0002, 32'h0000_0002, 32'h41C);
    // Jump and link, then a gap cycle
    addRow(1'b1, immInst(`OP1_JAL, 16'h0010, 4'd15), 32'h0000_4000, 32'h0, 32'h200);
    addRow(1'b0, immInst(`OP1_ADDI, 16'h0001, 4'd9), 32'h0000_0001, 32'h0, 32'h0);
    // Unknown opcode still writes a zero
    addRow(1'b1, immInst(6'b111111, 16'h1234, 4'd12), 32'hDEAD_BEEF, 32'h1, 32'h300);
    // Random filler traffic
    randA = $urandom();
    randB = $urandom();
    addRow(1'b1, alurInst(`OP2_ADD, 4'd6), randA, randB, 32'h500);
    randA = $urandom();
    randB = $urandom();
    addRow(1'b1, alurInst(`OP2_SUB, 4'd7), randA, randB, 32'h504);
    addRow(1'b0, alurInst(`OP2_OR, 4'd8), randA, randB, 32'h508);
    randA = $urandom();
    randB = $urandom();
    addRow(1'b1, immInst(`OP1_XORI, 16'hC3A5, 4'd9), randA, randB, 32'h50C);
    addRow(1'b1, alurInst(`OP2_XOR, 4'd10), randB, randA, 32'h510);
  endtask

  // ==================================================
  // Drive and check
  // ==================================================
  task automatic checkValue(input string name, input logic [`DBITS-1:0] got,
                            input logic [`DBITS-1:0] exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic driveRow(input int idx);
    inValid = rows[idx].valid;
    inst    = rows[idx].inst;
    regVal1 = rows[idx].val1;
    regVal2 = rows[idx].val2;
    pcPlus  = rows[idx].pc;
  endtask

  task automatic checkRow(input int idx);
    checkValue("outValid", 32'(outValid), 32'(rows[idx].valid));
    checkValue("wrReg", 32'(wrReg), 32'(rows[idx].expWrReg));
    checkValue("redirect", 32'(redirect), 32'(rows[idx].expRedirect));
    if (rows[idx].valid) begin
      checkValue("result", result, rows[idx].expResult);
      checkValue("wregNo", 32'(wregNo), 32'(rows[idx].expWregNo));
      // Target only matters on a redirect
      if (rows[idx].expRedirect)
        checkValue("target", target, rows[idx].expTarget);
    end
  endtask

  initial begin
    void'($urandom(32'h9b6e_6006));
    RESET   = 1'b1;
    inValid = 1'b0;
    inst    = '0;
    pcPlus  = '0;
    regVal1 = '0;
    regVal2 = '0;
    buildTable();
    repeat (3) @(posedge clk);
    #1;
    RESET = 1'b0;
    // Outputs idle out of reset
    checkValue("outValid", 32'(outValid), 32'd0);
    checkValue("wrReg", 32'(wrReg), 32'd0);
    checkValue("redirect", 32'(redirect), 32'd0);
    checkValue("result", result, 32'd0);
    // Each row is checked on the edge after it is driven
    for (int i = 0; i <= rowCount; i++) begin
      @(posedge clk);
      #1;
      if (i > 0)
        checkRow(i - 1);
      if (i < rowCount)
        driveRow(i);
      else
        inValid = 1'b0;
    end
    $display("TEST PASS");
    $finish;
  end

endmodule
